// ==== source/noc_defs.svh ====
// NoC size and field macros
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// ---------------------------------------
// Mesh shape and buffering
// ---------------------------------------
`define NOC_X_NODES      2   // Columns
`define NOC_Y_NODES      2   // Rows
`define NOC_QUEUE_DEPTH  4   // Entries per router input

// ---------------------------------------
// Packet field widths
// ---------------------------------------
`define NOC_COORD_W      2   // One X or Y coordinate
`define NOC_SRC_W        4   // Source node number
`define NOC_PAYLOAD_W    16  // User data

// Field positions, payload at the bottom
`define NOC_PAYLOAD_LSB  0
`define NOC_SRC_LSB      (`NOC_PAYLOAD_LSB + `NOC_PAYLOAD_W)
`define NOC_DEST_Y_LSB   (`NOC_SRC_LSB + `NOC_SRC_W)
`define NOC_DEST_X_LSB   (`NOC_DEST_Y_LSB + `NOC_COORD_W)
`define NOC_PACKET_W     (`NOC_DEST_X_LSB + `NOC_COORD_W)  // 24 bits

`endif

// ==== source/noc_packet_pkg.sv ====
// NoC packet types
`include "noc_defs.svh"

package noc_packet_pkg;

  typedef logic [`NOC_COORD_W-1:0]   coord_t;    // X or Y position
  typedef logic [`NOC_SRC_W-1:0]     node_id_t;  // Counted along X, then Y
  typedef logic [`NOC_PAYLOAD_W-1:0] payload_t;
  typedef logic [`NOC_PACKET_W-1:0]  packet_t;   // {dest_x, dest_y, src, payload}

  // Field access
  function automatic coord_t get_dest_x(packet_t pkt);
    return pkt[`NOC_DEST_X_LSB +: `NOC_COORD_W];
  endfunction

  function automatic coord_t get_dest_y(packet_t pkt);
    return pkt[`NOC_DEST_Y_LSB +: `NOC_COORD_W];
  endfunction

  function automatic node_id_t get_src(packet_t pkt);
    return pkt[`NOC_SRC_LSB +: `NOC_SRC_W];
  endfunction

  function automatic payload_t get_payload(packet_t pkt);
    return pkt[`NOC_PAYLOAD_LSB +: `NOC_PAYLOAD_W];
  endfunction

  // Build a packet word, top field first
  function automatic packet_t make_packet(coord_t dx, coord_t dy, node_id_t src, payload_t data);
    return {dx, dy, src, data};
  endfunction

endpackage

// ==== source/noc_router_pkg.sv ====
// NoC router port types
package noc_router_pkg;

  localparam int NUM_PORTS = 5;  // Local plus four neighbours

  // ---------------------------------------
  // Port numbering, shared by router and mesh
  // ---------------------------------------
  typedef enum logic [2:0] {
    PORT_LOCAL = 3'd0,  // Attached node
    PORT_NORTH = 3'd1,  // Towards y+1
    PORT_EAST  = 3'd2,  // Towards x+1
    PORT_SOUTH = 3'd3,  // Towards y-1
    PORT_WEST  = 3'd4   // Towards x-1
  } port_dir_t;

  // One bit per port, indexed by port_dir_t
  // Used for route requests and arbiter grants
  typedef logic [NUM_PORTS-1:0] port_mask_t;

endpackage

// ==== source/noc_input_queue.sv ====
// Router input FIFO
`timescale 1ns/10ps
`include "noc_defs.svh"

module noc_input_queue
  import noc_packet_pkg::*;
#(
  parameter int DEPTH = `NOC_QUEUE_DEPTH  // Number of entries
)(
  input  logic    clk,
  input  logic    i_reset,
  // Write side
  input  packet_t i_data,
  input  logic    i_valid,
  output logic    o_ready,   // Not full
  // Read side
  output packet_t o_data,    // Head word
  output logic    o_valid,   // Not empty
  input  logic    i_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);
  localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(DEPTH);

  packet_t          mem [DEPTH];  // Storage, no reset
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;        // Occupancy
  logic             push;
  logic             pop;

  assign o_ready = (count != FULL_CNT);
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];   // Head seen one cycle after write
  assign push    = i_valid && o_ready;
  assign pop     = o_valid && i_ready;

  // Pointers and count
  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;  // Wrap
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule

// ==== source/noc_output_arbiter.sv ====
// Round-robin output arbiter
`timescale 1ns/10ps

module noc_output_arbiter
  import noc_router_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  port_mask_t i_request,  // Inputs routed to this output
  input  logic       i_advance,  // Granted packet taken this cycle
  output port_mask_t o_grant     // One-hot, or zero when idle
);

  port_dir_t ptr;       // Input with top priority
  port_dir_t win;       // Current winner
  port_dir_t win_next;  // Input just after the winner
  logic      any_req;

  // ---------------------------------------
  // Grant search from the pointer
  // ---------------------------------------
  always_comb begin
    int idx;
    o_grant = '0;
    win     = ptr;
    any_req = 1'b0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      idx = (int'(ptr) + k) % NUM_PORTS;  // Rotate from ptr
      if (!any_req && i_request[idx]) begin
        any_req      = 1'b1;
        win          = port_dir_t'(idx);
        o_grant[idx] = 1'b1;
      end
    end
  end

  assign win_next = (win == PORT_WEST) ? PORT_LOCAL : port_dir_t'(win + 3'd1);

  // Pointer update
  // While stalled the pointer parks on the winner, so a later request
  // from a lower-priority input cannot take the output mid-transfer
  always_ff @(posedge clk) begin
    if (i_reset) begin
      ptr <= PORT_LOCAL;
    end else if (any_req) begin
      ptr <= i_advance ? win_next : win;  // Move past winner on transfer
    end
  end

endmodule

// ==== source/noc_router.sv ====
// Five-port XY router
`timescale 1ns/10ps
`include "noc_defs.svh"

module noc_router
  import noc_packet_pkg::*;
  import noc_router_pkg::*;
#(
  parameter int X_LOC   = 0,             // Column of this router
  parameter int Y_LOC   = 0,             // Row of this router
  parameter int X_NODES = `NOC_X_NODES,
  parameter int Y_NODES = `NOC_Y_NODES
)(
  input  logic                          clk,
  input  logic                          i_reset,
  // Inputs from node and neighbours
  input  packet_t [0:NUM_PORTS-1]       i_data,
  input  logic    [0:NUM_PORTS-1]       i_valid,
  output logic    [0:NUM_PORTS-1]       o_ready,
  // Outputs to node and neighbours
  output packet_t [0:NUM_PORTS-1]       o_data,
  output logic    [0:NUM_PORTS-1]       o_valid,
  input  logic    [0:NUM_PORTS-1]       i_ready
);

  localparam coord_t MY_X = coord_t'(X_LOC);
  localparam coord_t MY_Y = coord_t'(Y_LOC);

  // Outputs with a link at this grid position, {W, S, E, N, L}
  localparam port_mask_t LINKS = {(X_LOC > 0), (Y_LOC > 0), (X_LOC < X_NODES - 1),
                                  (Y_LOC < Y_NODES - 1), 1'b1};

  packet_t              q_data  [NUM_PORTS];  // Queue heads
  logic [0:NUM_PORTS-1] q_valid;
  logic [0:NUM_PORTS-1] q_pop;
  port_mask_t           req     [NUM_PORTS];  // Per input, which output
  port_mask_t           out_req [NUM_PORTS];  // Per output, which inputs
  port_mask_t           gnt     [NUM_PORTS];  // Per output grant
  logic [0:NUM_PORTS-1] adv;                  // Output transfers

  // X first, then Y, then deliver
  function automatic port_dir_t xy_route(packet_t pkt);
    return (get_dest_x(pkt) > MY_X) ? PORT_EAST  :
           (get_dest_x(pkt) < MY_X) ? PORT_WEST  :
           (get_dest_y(pkt) > MY_Y) ? PORT_NORTH :
           (get_dest_y(pkt) < MY_Y) ? PORT_SOUTH : PORT_LOCAL;
  endfunction

  // ---------------------------------------
  // Per-port queue, route and arbiter
  // ---------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    noc_input_queue u_queue (
      .clk     (clk),
      .i_reset (i_reset),
      .i_data  (i_data[p]),
      .i_valid (i_valid[p]),
      .o_ready (o_ready[p]),
      .o_data  (q_data[p]),
      .o_valid (q_valid[p]),
      .i_ready (q_pop[p])
    );

    assign req[p] = q_valid[p] ? ((port_mask_t'(1) << xy_route(q_data[p])) & LINKS) : '0;
    assign adv[p] = o_valid[p] & i_ready[p];  // Packet leaves this output

    noc_output_arbiter u_arb (
      .clk       (clk),
      .i_reset   (i_reset),
      .i_request (out_req[p]),
      .i_advance (adv[p]),
      .o_grant   (gnt[p])
    );
  end

  // Requests regrouped by output
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        out_req[o][i] = req[i][o];
      end
    end
  end

  // Crossbar, output follows its granted input
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      o_data[o]  = '0;
      o_valid[o] = |gnt[o];
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (gnt[o][i]) begin
          o_data[o] = q_data[i];
        end
      end
    end
  end

  // Head pops when its granted output is ready
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      q_pop[i] = 1'b0;
      for (int o = 0; o < NUM_PORTS; o++) begin
        q_pop[i] = q_pop[i] | (gnt[o][i] & i_ready[o]);
      end
    end
  end

endmodule

// ==== source/noc_mesh.sv ====
// 2D mesh network of routers
`timescale 1ns/10ps
`include "noc_defs.svh"

module noc_mesh
  import noc_packet_pkg::*;
  import noc_router_pkg::*;
#(
  parameter  int X_NODES = `NOC_X_NODES,  // Columns
  parameter  int Y_NODES = `NOC_Y_NODES,  // Rows
  localparam int NODES   = X_NODES * Y_NODES
)(
  input  logic                  clk,
  input  logic                  i_reset,
  // Node to network
  input  packet_t [0:NODES-1]   i_data,
  input  logic    [0:NODES-1]   i_valid,
  output logic    [0:NODES-1]   o_ready,
  // Network to node
  output packet_t [0:NODES-1]   o_data,
  output logic    [0:NODES-1]   o_valid,
  input  logic    [0:NODES-1]   i_ready
);

  // Router side of every link, [router][port]
  packet_t [0:NODES-1][0:NUM_PORTS-1] rin_data;
  logic    [0:NODES-1][0:NUM_PORTS-1] rin_valid;
  logic    [0:NODES-1][0:NUM_PORTS-1] rin_ready;   // From router queues
  packet_t [0:NODES-1][0:NUM_PORTS-1] rout_data;
  logic    [0:NODES-1][0:NUM_PORTS-1] rout_valid;
  logic    [0:NODES-1][0:NUM_PORTS-1] rout_ready;  // Into router crossbar

  // ---------------------------------------
  // Router grid, numbered along X then Y
  // ---------------------------------------
  for (genvar y = 0; y < Y_NODES; y++) begin : gen_y
    for (genvar x = 0; x < X_NODES; x++) begin : gen_x
      localparam int N = y * X_NODES + x;

      assign rin_data[N][PORT_LOCAL]   = i_data[N];      // Node injects
      assign rin_valid[N][PORT_LOCAL]  = i_valid[N];
      assign o_ready[N]                = rin_ready[N][PORT_LOCAL];
      assign o_data[N]                 = rout_data[N][PORT_LOCAL];  // Node ejects
      assign o_valid[N]                = rout_valid[N][PORT_LOCAL];
      assign rout_ready[N][PORT_LOCAL] = i_ready[N];

      // Neighbour links, each side fed by the facing port of the next router
      for (genvar d = 1; d < NUM_PORTS; d++) begin : gen_link
        localparam bit HAS_NB = (d == PORT_NORTH) ? (y < Y_NODES - 1) :
                                (d == PORT_EAST)  ? (x < X_NODES - 1) :
                                (d == PORT_SOUTH) ? (y > 0) : (x > 0);
        localparam int NB  = (d == PORT_NORTH) ? N + X_NODES :
                             (d == PORT_EAST)  ? N + 1 :
                             (d == PORT_SOUTH) ? N - X_NODES : N - 1;
        localparam int OPP = (d + 1) % 4 + 1;  // N<->S, E<->W

        if (HAS_NB) begin : gen_nb
          assign rin_data[N][d]   = rout_data[NB][OPP];
          assign rin_valid[N][d]  = rout_valid[NB][OPP];
          assign rout_ready[N][d] = rin_ready[NB][OPP];
        end else begin : gen_edge
          assign rin_data[N][d]   = '0;    // Mesh edge, nothing arrives
          assign rin_valid[N][d]  = 1'b0;
          assign rout_ready[N][d] = 1'b0;  // Never requested by XY route
        end
      end

      noc_router #(
        .X_LOC   (x),
        .Y_LOC   (y),
        .X_NODES (X_NODES),
        .Y_NODES (Y_NODES)
      ) u_router (
        .clk     (clk),
        .i_reset (i_reset),
        .i_data  (rin_data[N]),
        .i_valid (rin_valid[N]),
        .o_ready (rin_ready[N]),
        .o_data  (rout_data[N]),
        .o_valid (rout_valid[N]),
        .i_ready (rout_ready[N])
      );
    end
  end

endmodule

// ==== bench/noc_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/10ps

module noc_clock_gen #(
  parameter int PERIOD       = 100,  // ns
  parameter int RESET_CYCLES = 8
)(
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_reset = 1'b0;  // Same skew as stimulus
  end

endmodule

// ==== bench/noc_mesh_assert.sv ====
// Node port checks for the mesh
`timescale 1ns/10ps
`include "noc_defs.svh"

module noc_mesh_assert
  import noc_packet_pkg::*;
#(
  parameter int NODES = `NOC_X_NODES * `NOC_Y_NODES
)(
  input logic                clk,
  input logic                i_reset,
  input logic    [0:NODES-1] i_valid,  // Node offers
  input logic    [0:NODES-1] o_ready,
  input packet_t [0:NODES-1] o_data,   // Node deliveries
  input logic    [0:NODES-1] o_valid,
  input logic    [0:NODES-1] i_ready
);

  int   fail_cnt = 0;  // Failed assertions so far
  logic offered;       // Sticky, some node offered a packet

  always_ff @(posedge clk) begin
    if (i_reset) begin
      offered <= 1'b0;
    end else if (|i_valid) begin
      offered <= 1'b1;
    end
  end

  // Idle network until first offer
  reset_idle: assert property (@(posedge clk) disable iff (i_reset)
    !offered |-> (o_valid == '0) && (o_ready == '1))
    else begin
      $error("network not idle after reset");
      fail_cnt++;
    end

  // ----------------------------------------
  // Per node delivery port
  // ----------------------------------------
  for (genvar n = 0; n < NODES; n++) begin : gen_node
    hold_on_stall: assert property (@(posedge clk) disable iff (i_reset)
      o_valid[n] && !i_ready[n] |=> o_valid[n] && $stable(o_data[n]))
      else begin
        $error("node %0d output changed while stalled", n);
        fail_cnt++;
      end

    quiet_in_reset: assert property (@(posedge clk)
      i_reset |-> !$rose(o_valid[n]))  // Nothing leaves during reset
      else begin
        $error("node %0d raised o_valid during reset", n);
        fail_cnt++;
      end
  end

endmodule

bind noc_mesh noc_mesh_assert #(.NODES(X_NODES * Y_NODES)) u_checks (
  .clk     (clk),
  .i_reset (i_reset),
  .i_valid (i_valid),
  .o_ready (o_ready),
  .o_data  (o_data),
  .o_valid (o_valid),
  .i_ready (i_ready)
);

// ==== bench/noc_mesh_tb.sv ====
// NoC mesh testbench
`timescale 1ns/10ps
`include "noc_defs.svh"

module noc_mesh_tb
  import noc_packet_pkg::*;
();

  localparam int X_NODES = `NOC_X_NODES;
  localparam int Y_NODES = `NOC_Y_NODES;
  localparam int NODES   = X_NODES * Y_NODES;
  localparam int TIMEOUT = 2000;  // Cycles per wait

  logic                clk;
  logic                i_reset;
  packet_t [0:NODES-1] i_data;
  logic    [0:NODES-1] i_valid;
  logic    [0:NODES-1] o_ready;
  packet_t [0:NODES-1] o_data;
  logic    [0:NODES-1] o_valid;
  logic    [0:NODES-1] i_ready;

  packet_t          exp_q [NODES][$];  // Scoreboard per destination
  logic [0:NODES-1] stalled;           // Source saw o_ready low
  string            test_name;
  int               errors   = 0;
  int               sent     = 0;
  int               received = 0;
  int               tests    = 0;
  int               active   = 0;      // Senders still running
  int               seed     = 32'h5773;

  noc_clock_gen u_clk_gen (
    .o_clk   (clk),
    .o_reset (i_reset)
  );

  noc_mesh #(
    .X_NODES (X_NODES),
    .Y_NODES (Y_NODES)
  ) dut0 (
    .clk     (clk),
    .i_reset (i_reset),
    .i_data  (i_data),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .o_data  (o_data),
    .o_valid (o_valid),
    .i_ready (i_ready)
  );

  // Offer one packet and hold it until taken
  task automatic send_packet(input int src, input int dest, input payload_t data);
    packet_t pkt;
    int      cycles;
    pkt = {coord_t'(dest % X_NODES), coord_t'(dest / X_NODES), node_id_t'(src), data};
    i_data[src]  = pkt;
    i_valid[src] = 1'b1;
    cycles = 0;
    while (!o_ready[src] && cycles < TIMEOUT) begin
      stalled[src] = 1'b1;
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (o_ready[src]) else begin
      $display("%s: timeout, node %0d never accepted a packet", test_name, src);
      errors++;
    end
    if (o_ready[src]) begin
      exp_q[dest].push_back(pkt);  // Taken on the coming edge
      sent++;
    end
    @(posedge clk);
    #1;
    i_valid[src] = 1'b0;
  endtask

  // Match against oldest pending packet of the same source
  function automatic void check_delivery(int node, packet_t got);
    int idx;
    idx = -1;
    for (int k = exp_q[node].size() - 1; k >= 0; k--) begin
      if (get_src(exp_q[node][k]) == get_src(got)) begin
        idx = k;
      end
    end
    assert (idx >= 0) else begin
      $display("%s: unexpected packet %h at node %0d", test_name, got, node);
      errors++;
    end
    if (idx >= 0) begin
      assert (got == exp_q[node][idx]) else begin
        $display("mismatch %s: expected %h actual %h", test_name, exp_q[node][idx], got);
        errors++;
      end
      exp_q[node].delete(idx);
    end
    received++;
  endfunction

  // Receivers sample on the clock edge
  always @(posedge clk) begin
    if (!i_reset) begin
      for (int n = 0; n < NODES; n++) begin
        if (o_valid[n] && i_ready[n]) check_delivery(n, o_data[n]);
      end
    end
  end

  task automatic wait_senders();
    int cycles;
    cycles = 0;
    while (active > 0 && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (active == 0) else begin
      $display("%s: timeout, %0d senders still busy", test_name, active);
      errors++;
    end
  endtask

  // Wait until every expected queue is empty
  task automatic wait_drain(input int errors_before);
    int cycles;
    int left;
    cycles = 0;
    left   = 1;
    while (left > 0 && cycles < TIMEOUT) begin
      left = 0;
      for (int n = 0; n < NODES; n++) left += exp_q[n].size();
      if (left > 0) begin
        @(posedge clk);
        #1;
      end
      cycles++;
    end
    assert (left == 0) else begin
      $display("%s: timeout, %0d packets never delivered", test_name, left);
      errors++;
    end
    tests++;
    $display("test %s finished, %0d errors", test_name, errors - errors_before);
  endtask

  initial begin
    int errors_before;
    int cycles;
    i_data  = '0;
    i_valid = '1;  // Offers during reset must be ignored
    i_ready = '1;
    stalled = '0;
    cycles  = 0;
    repeat (4) @(posedge clk);
    #1;
    i_valid = '0;
    while (i_reset !== 1'b0 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    @(posedge clk);
    #1;

    // Idle network under the bound checks
    test_name     = "reset_state";
    errors_before = errors;
    repeat (4) @(posedge clk);
    #1;
    wait_drain(errors_before);

    // ----------------------------------------
    // Every source to every destination
    // ----------------------------------------
    test_name     = "all_pairs";
    errors_before = errors;
    active        = NODES;
    for (int s = 0; s < NODES; s++) begin
      fork
        automatic int src = s;
        begin
          for (int d = 0; d < NODES; d++) send_packet(src, d, payload_t'(src * 256 + d));
          active--;
        end
      join_none
    end
    wait_senders();
    wait_drain(errors_before);

    // Node 0 stalls while the others flood it
    test_name     = "back_pressure";
    errors_before = errors;
    stalled       = '0;
    i_ready[0]    = 1'b0;
    active        = NODES - 1;
    for (int s = 1; s < NODES; s++) begin
      fork
        automatic int src = s;
        begin
          for (int k = 0; k < 16; k++) send_packet(src, 0, payload_t'(src * 256 + k));
          active--;
        end
      join_none
    end
    cycles = 0;
    while (stalled[1:NODES-1] != '1 && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (stalled[1:NODES-1] == '1) else begin
      $display("%s: some sources never saw o_ready low", test_name);
      errors++;
    end
    i_ready[0] = 1'b1;
    wait_senders();
    wait_drain(errors_before);

    // ----------------------------------------
    // Random destinations and sink stalls
    // ----------------------------------------
    test_name     = "random_traffic";
    errors_before = errors;
    active        = NODES;
    for (int s = 0; s < NODES; s++) begin
      fork
        automatic int src = s;
        begin
          for (int k = 0; k < 20; k++) begin
            send_packet(src, $unsigned($random(seed)) % NODES, payload_t'($random(seed)));
          end
          active--;
        end
      join_none
    end
    cycles = 0;
    while (active > 0 && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      i_ready = NODES'($random(seed));
      cycles++;
    end
    i_ready = '1;
    wait_senders();
    wait_drain(errors_before);

    assert (received == sent) else begin
      $display("mismatch packet_count: expected %0d actual %0d", sent, received);
      errors++;
    end
    errors += dut0.u_checks.fail_cnt;  // Bound assertion failures
    $display("tests %0d, sent %0d, received %0d, errors %0d", tests, sent, received, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+source
source/noc_packet_pkg.sv
source/noc_router_pkg.sv
source/noc_input_queue.sv
source/noc_output_arbiter.sv
source/noc_router.sv
source/noc_mesh.sv
bench/noc_clock_gen.sv
bench/noc_mesh_assert.sv
bench/noc_mesh_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the NoC mesh testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module noc_mesh_tb \
  -Mdir obj_dir > sim.log 2>&1 &&
./obj_dir/Vnoc_mesh_tb >> sim.log 2>&1 ||
echo "*** TEST FAILED ***" >> sim.log
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0
